//--- hdl/fifo_addr_gen.sv
`timescale 1ns/1ps

module fifo_addr_gen (
   input  logic                    pos_clk,
   input  logic                    aresetn,
   input  fifo_bus_pkg::fifo_acc_t acc_i,
   output fifo_cfg_pkg::addr_t     waddr_o,
   output fifo_cfg_pkg::addr_t     raddr_o
);

   // last valid slot before wrapping back to 0
   localparam fifo_cfg_pkg::addr_t LAST = fifo_cfg_pkg::addr_t'(fifo_cfg_pkg::DEPTH - 1);

   fifo_cfg_pkg::addr_t wptr_r;
   fifo_cfg_pkg::addr_t rptr_r;

   // --------------------------------------------------
   // pointers
   // --------------------------------------------------
   always_ff @(posedge pos_clk or negedge aresetn) begin
      if (!aresetn) begin
         wptr_r <= '0;
         rptr_r <= '0;
      end else begin
         if (acc_i.wr_ok) begin
            wptr_r <= (wptr_r == LAST) ? '0 : wptr_r + 1'b1;   // wrap at depth
         end
         if (acc_i.rd_ok) begin
            rptr_r <= (rptr_r == LAST) ? '0 : rptr_r + 1'b1;
         end
      end
   end

   // ram samples these at the accepting edge
   assign waddr_o = wptr_r;
   assign raddr_o = rptr_r;

endmodule

//--- hdl/fifo_bus_pkg.sv
package fifo_bus_pkg;

   // --------------------------------------------------
   // raw requests as seen at the top-level ports
   // --------------------------------------------------
   typedef struct packed {
      logic                we;      // write request
      logic                re;      // read request
      fifo_cfg_pkg::data_t wdata;   // word offered with a write
   } fifo_req_t;

   // --------------------------------------------------
   // outcome of one cycle after qualification
   // --------------------------------------------------

   // accept bits move data and pointers
   // refuse bits only raise overflow or underflow
   typedef struct packed {
      logic wr_ok;      // write accepted, not full
      logic rd_ok;      // read accepted, not empty
      logic wr_ref;     // write refused while full
      logic rd_ref;     // read refused while empty
   } fifo_acc_t;

endpackage

//--- hdl/fifo_cfg_pkg.sv
package fifo_cfg_pkg;

   // --------------------------------------------------
   // geometry of the word store
   // --------------------------------------------------
   localparam int DATA_W = 16;      // bits per stored word
   localparam int ADDR_W = 4;       // bits per storage address
   localparam int DEPTH  = 16;      // entries, equal to 2**ADDR_W here

   // --------------------------------------------------
   // vector types with a meaning
   // --------------------------------------------------

   // one word as written and read
   typedef logic [DATA_W-1:0] data_t;

   // index into the store, wraps at DEPTH
   typedef logic [ADDR_W-1:0] addr_t;

   // occupancy 0..DEPTH, needs one bit more than an address
   typedef logic [ADDR_W:0] level_t;

endpackage

//--- hdl/fifo_occupancy.sv
`timescale 1ns/1ps

module fifo_occupancy (
   input  logic                    pos_clk,
   input  logic                    aresetn,
   input  fifo_bus_pkg::fifo_req_t req_i,
   output fifo_bus_pkg::fifo_acc_t acc_o,
   output fifo_cfg_pkg::level_t    level_o,
   output logic                    full_o,
   output logic                    empty_o
);

   localparam fifo_cfg_pkg::level_t LVL_FULL = fifo_cfg_pkg::level_t'(fifo_cfg_pkg::DEPTH);
   localparam fifo_cfg_pkg::level_t LVL_ONE  = fifo_cfg_pkg::level_t'(1);

   fifo_cfg_pkg::level_t level_r;      // current occupancy
   fifo_cfg_pkg::level_t level_nxt;    // occupancy after this edge
   logic                 full_r;
   logic                 empty_r;
   logic                 wr_ok;
   logic                 rd_ok;

   // --------------------------------------------------
   // request qualification
   // --------------------------------------------------

   // judged against the registered flags, not the next level
   assign wr_ok = req_i.we & ~full_r;
   assign rd_ok = req_i.re & ~empty_r;

   always_comb begin
      acc_o.wr_ok  = wr_ok;
      acc_o.rd_ok  = rd_ok;
      acc_o.wr_ref = req_i.we & full_r;    // dropped, overflow
      acc_o.rd_ref = req_i.re & empty_r;   // nothing to give, underflow
   end

   // --------------------------------------------------
   // level counter
   // --------------------------------------------------
   always_comb begin
      level_nxt = level_r;
      case ({wr_ok, rd_ok})
         2'b10:   level_nxt = level_r + LVL_ONE;   // write only
         2'b01:   level_nxt = level_r - LVL_ONE;   // read only
         default: level_nxt = level_r;             // idle or both, no change
      endcase
   end

   always_ff @(posedge pos_clk or negedge aresetn) begin
      if (!aresetn) begin
         level_r <= '0;
         full_r  <= 1'b0;
         empty_r <= 1'b1;     // starts empty
      end else begin
         level_r <= level_nxt;
         full_r  <= (level_nxt == LVL_FULL);
         empty_r <= (level_nxt == '0);
      end
   end

   // all outputs straight from flops
   assign level_o = level_r;
   assign full_o  = full_r;
   assign empty_o = empty_r;

endmodule

//--- hdl/fifo_ram.sv
`timescale 1ns/1ps

module fifo_ram (
   input  logic                    pos_clk,
   input  fifo_bus_pkg::fifo_acc_t acc_i,
   input  fifo_cfg_pkg::addr_t     waddr_i,
   input  fifo_cfg_pkg::addr_t     raddr_i,
   input  fifo_cfg_pkg::data_t     wdata_i,
   output fifo_cfg_pkg::data_t     rdata_o
);

   fifo_cfg_pkg::data_t mem [fifo_cfg_pkg::DEPTH];    // word store
   fifo_cfg_pkg::data_t rdata_r;

   // --------------------------------------------------
   // write port
   // --------------------------------------------------
   always_ff @(posedge pos_clk) begin
      if (acc_i.wr_ok) begin
         mem[waddr_i] <= wdata_i;
      end
   end

   // --------------------------------------------------
   // registered read port
   // --------------------------------------------------

   // pointers only meet when empty or full
   // so an accepted read never hits the slot being written
   always_ff @(posedge pos_clk) begin
      if (acc_i.rd_ok) begin
         rdata_r <= mem[raddr_i];    // else hold last word
      end
   end

   assign rdata_o = rdata_r;

endmodule

//--- hdl/fifo_status_flags.sv
`timescale 1ns/1ps

module fifo_status_flags #(
   parameter fifo_cfg_pkg::level_t AFULL_VAL  = 12,    // afull at or above
   parameter fifo_cfg_pkg::level_t AEMPTY_VAL = 3      // aempty at or below
) (
   input  logic                    pos_clk,
   input  logic                    aresetn,
   input  fifo_bus_pkg::fifo_acc_t acc_i,
   input  fifo_cfg_pkg::level_t    level_i,
   output logic                    afull_o,
   output logic                    aempty_o,
   output logic                    wack_o,
   output logic                    dvld_o,
   output logic                    overflow_o,
   output logic                    underflow_o
);

   fifo_cfg_pkg::level_t level_nxt;    // level as it will be after this edge

   logic afull_r;
   logic aempty_r;
   logic wack_r;
   logic dvld_r;
   logic ovf_r;
   logic unf_r;

   // --------------------------------------------------
   // next occupancy
   // --------------------------------------------------

   // mirrors the counter so thresholds line up with level_o
   // both accepted gives +1 -1, level unchanged
   assign level_nxt = level_i
                    + fifo_cfg_pkg::level_t'(acc_i.wr_ok)
                    - fifo_cfg_pkg::level_t'(acc_i.rd_ok);

   // --------------------------------------------------
   // registered flags
   // --------------------------------------------------
   always_ff @(posedge pos_clk or negedge aresetn) begin
      if (!aresetn) begin
         afull_r  <= 1'b0;
         aempty_r <= 1'b1;    // level 0 is below any threshold
         wack_r   <= 1'b0;
         dvld_r   <= 1'b0;
         ovf_r    <= 1'b0;
         unf_r    <= 1'b0;
      end else begin
         afull_r  <= (level_nxt >= AFULL_VAL);
         aempty_r <= (level_nxt <= AEMPTY_VAL);
         // single-cycle pulses, one per sampled request
         wack_r   <= acc_i.wr_ok;
         dvld_r   <= acc_i.rd_ok;     // same edge as rdata register
         ovf_r    <= acc_i.wr_ref;
         unf_r    <= acc_i.rd_ref;
      end
   end

   assign afull_o     = afull_r;
   assign aempty_o    = aempty_r;
   assign wack_o      = wack_r;
   assign dvld_o      = dvld_r;
   assign overflow_o  = ovf_r;
   assign underflow_o = unf_r;

endmodule

//--- hdl/sync_fifo_top.sv
`timescale 1ns/1ps

module sync_fifo_top #(
   parameter fifo_cfg_pkg::level_t AFULL_VAL  = 12,
   parameter fifo_cfg_pkg::level_t AEMPTY_VAL = 3
) (
   input  logic                 pos_clk,
   input  logic                 aresetn,
   input  logic                 we_i,        // write request
   input  logic                 re_i,        // read request
   input  fifo_cfg_pkg::data_t  wdata_i,
   output fifo_cfg_pkg::data_t  rdata_o,     // valid with dvld_o
   output fifo_cfg_pkg::level_t level_o,
   output logic                 full_o,
   output logic                 empty_o,
   output logic                 afull_o,
   output logic                 aempty_o,
   output logic                 wack_o,
   output logic                 dvld_o,
   output logic                 overflow_o,
   output logic                 underflow_o
);

   fifo_bus_pkg::fifo_req_t req;
   fifo_bus_pkg::fifo_acc_t acc;       // fans out to flags, pointers, ram
   fifo_cfg_pkg::level_t    level;
   fifo_cfg_pkg::addr_t     waddr;
   fifo_cfg_pkg::addr_t     raddr;

   // bundle the port requests
   assign req.we    = we_i;
   assign req.re    = re_i;
   assign req.wdata = wdata_i;

   // --------------------------------------------------
   // control
   // --------------------------------------------------
   fifo_occupancy i_occ (
      .pos_clk (pos_clk),
      .aresetn (aresetn),
      .req_i   (req),
      .acc_o   (acc),
      .level_o (level),
      .full_o  (full_o),
      .empty_o (empty_o)
   );

   fifo_status_flags #(
      .AFULL_VAL  (AFULL_VAL),
      .AEMPTY_VAL (AEMPTY_VAL)
   ) i_flags (
      .pos_clk     (pos_clk),
      .aresetn     (aresetn),
      .acc_i       (acc),
      .level_i     (level),
      .afull_o     (afull_o),
      .aempty_o    (aempty_o),
      .wack_o      (wack_o),
      .dvld_o      (dvld_o),
      .overflow_o  (overflow_o),
      .underflow_o (underflow_o)
   );

   assign level_o = level;

   // --------------------------------------------------
   // datapath
   // --------------------------------------------------
   fifo_addr_gen i_addr (
      .pos_clk (pos_clk),
      .aresetn (aresetn),
      .acc_i   (acc),
      .waddr_o (waddr),
      .raddr_o (raddr)
   );

   fifo_ram i_ram (
      .pos_clk (pos_clk),
      .acc_i   (acc),
      .waddr_i (waddr),
      .raddr_i (raddr),
      .wdata_i (req.wdata),   // word bypasses the counter
      .rdata_o (rdata_o)
   );

endmodule

//--- list.f
hdl/fifo_cfg_pkg.sv
hdl/fifo_bus_pkg.sv
hdl/fifo_occupancy.sv
hdl/fifo_status_flags.sv
hdl/fifo_addr_gen.sv
hdl/fifo_ram.sv
hdl/sync_fifo_top.sv
verif/sync_fifo_assert.sv
verif/tb_sync_fifo.sv

//--- run_sim.sh
#!/bin/sh
# build the testbench with verilator and run it from the project root
# exit status is 0 only when the pass line shows up in the output

cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal \
   --top-module tb_sync_fifo -f list.f -o sim_fifo &&
./obj_dir/sim_fifo | grep "Simulation finished: PASS" &&
echo "sync fifo run passed" ||
{ echo "sync fifo run failed"; exit 1; }

//--- verif/sync_fifo_assert.sv
`timescale 1ns/1ps

module sync_fifo_assert (
   input logic                 pos_clk,
   input logic                 aresetn,
   input logic                 we_i,
   input logic                 re_i,
   input fifo_cfg_pkg::level_t level_o,
   input logic                 full_o,
   input logic                 empty_o,
   input logic                 dvld_o,
   input logic                 overflow_o
);

   int fail_cnt = 0;     // read by the testbench at the end

   // --------------------------------------------------
   // port level properties
   // --------------------------------------------------
   a_not_full_and_empty: assert property (@(posedge pos_clk) disable iff (!aresetn)
      !(full_o && empty_o))
      else begin
         fail_cnt <= fail_cnt + 1;
         $error("full and empty high in the same cycle");
      end

   a_level_in_range: assert property (@(posedge pos_clk) disable iff (!aresetn)
      level_o <= fifo_cfg_pkg::level_t'(fifo_cfg_pkg::DEPTH))
      else begin
         fail_cnt <= fail_cnt + 1;
         $error("level above depth");
      end

   // data valid only after a read that was taken
   a_dvld_after_read: assert property (@(posedge pos_clk) disable iff (!aresetn)
      dvld_o |-> $past(re_i && !empty_o))
      else begin
         fail_cnt <= fail_cnt + 1;
         $error("dvld without an accepted read");
      end

   a_ovf_after_full_write: assert property (@(posedge pos_clk) disable iff (!aresetn)
      overflow_o |-> $past(we_i && full_o))
      else begin
         fail_cnt <= fail_cnt + 1;
         $error("overflow without a write while full");
      end

endmodule

bind sync_fifo_top sync_fifo_assert i_assert (
   .pos_clk    (pos_clk),
   .aresetn    (aresetn),
   .we_i       (we_i),
   .re_i       (re_i),
   .level_o    (level_o),
   .full_o     (full_o),
   .empty_o    (empty_o),
   .dvld_o     (dvld_o),
   .overflow_o (overflow_o)
);

//--- verif/tb_sync_fifo.sv
`timescale 1ns/1ps

module tb_sync_fifo;

   // --------------------------------------------------
   // run parameters
   // --------------------------------------------------
   localparam realtime CLK_PERIOD = 40.0;
   localparam realtime DRIVE_SKEW = 2.0;             // inputs change after the edge
   localparam int      PHASE_LEN  = 500;             // three phases
   localparam int      TEST_LEN   = 3 * PHASE_LEN;
   localparam int      CYCLE_LIMIT = TEST_LEN + 100;
   localparam logic [31:0] SEED   = 32'he3e4_697f;

   localparam fifo_cfg_pkg::level_t AFULL_VAL  = 12;
   localparam fifo_cfg_pkg::level_t AEMPTY_VAL = 3;

   logic                 pos_clk;
   logic                 aresetn;
   logic                 we;
   logic                 re;
   fifo_cfg_pkg::data_t  wdata;
   fifo_cfg_pkg::data_t  rdata;
   fifo_cfg_pkg::level_t level;
   logic                 full;
   logic                 empty;
   logic                 afull;
   logic                 aempty;
   logic                 wack;
   logic                 dvld;
   logic                 ovf;
   logic                 unf;

   logic [31:0]          lfsr_state;
   int                   cycle_cnt;

   // model queue plus registered copies of what the dut should show
   fifo_cfg_pkg::data_t  model_q[$];
   fifo_cfg_pkg::data_t  exp_rdata;
   fifo_cfg_pkg::level_t exp_level;
   logic                 exp_full;
   logic                 exp_empty;
   logic                 exp_afull;
   logic                 exp_aempty;
   logic                 exp_wack;
   logic                 exp_dvld;
   logic                 exp_ovf;
   logic                 exp_unf;
   logic                 rd_seen;      // rdata_o defined once a read was taken

   // corner cases the run has to reach
   logic                 seen_full;
   logic                 seen_ovf;
   logic                 seen_unf;
   logic                 seen_both;

   sync_fifo_top #(
      .AFULL_VAL  (AFULL_VAL),
      .AEMPTY_VAL (AEMPTY_VAL)
   ) i_dut (
      .pos_clk     (pos_clk),
      .aresetn     (aresetn),
      .we_i        (we),
      .re_i        (re),
      .wdata_i     (wdata),
      .rdata_o     (rdata),
      .level_o     (level),
      .full_o      (full),
      .empty_o     (empty),
      .afull_o     (afull),
      .aempty_o    (aempty),
      .wack_o      (wack),
      .dvld_o      (dvld),
      .overflow_o  (ovf),
      .underflow_o (unf)
   );

   initial begin
      pos_clk = 1'b0;
      forever #(CLK_PERIOD / 2) pos_clk = ~pos_clk;
   end

   // --------------------------------------------------
   // random source
   // --------------------------------------------------

   // taps 32 22 2 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      logic fb;
      fb = s[31] ^ s[21] ^ s[1] ^ s[0];
      return {s[30:0], fb};
   endfunction

   function automatic logic take_bit();
      lfsr_state = lfsr_next(lfsr_state);
      return lfsr_state[0];
   endfunction

   // --------------------------------------------------
   // compare tasks
   // --------------------------------------------------
   task automatic check_data(input string name, input fifo_cfg_pkg::data_t exp_v,
                             input fifo_cfg_pkg::data_t act_v);
      if (exp_v !== act_v) begin
         $display("[FAIL] %s expected 0x%h actual 0x%h", name, exp_v, act_v);
         $display("Simulation finished: FAIL");
         $fatal(1, "data mismatch on %s", name);
      end
   endtask

   task automatic check_level(input string name, input fifo_cfg_pkg::level_t exp_v,
                              input fifo_cfg_pkg::level_t act_v);
      if (exp_v !== act_v) begin
         $display("[FAIL] %s expected 0x%h actual 0x%h", name, exp_v, act_v);
         $display("Simulation finished: FAIL");
         $fatal(1, "level mismatch on %s", name);
      end
   endtask

   task automatic check_bit(input string name, input logic exp_v, input logic act_v);
      if (exp_v !== act_v) begin
         $display("[FAIL] %s expected 0x%h actual 0x%h", name, exp_v, act_v);
         $display("Simulation finished: FAIL");
         $fatal(1, "flag mismatch on %s", name);
      end
   endtask

   // fixed values straight after reset release
   task automatic check_reset_state();
      check_level("level_o", '0, level);
      check_bit("full_o", 1'b0, full);
      check_bit("empty_o", 1'b1, empty);
      check_bit("afull_o", 1'b0, afull);
      check_bit("aempty_o", 1'b1, aempty);
      check_bit("wack_o", 1'b0, wack);
      check_bit("dvld_o", 1'b0, dvld);
      check_bit("overflow_o", 1'b0, ovf);
      check_bit("underflow_o", 1'b0, unf);
   endtask

   task automatic check_outputs();
      check_level("level_o", exp_level, level);
      check_bit("full_o", exp_full, full);
      check_bit("empty_o", exp_empty, empty);
      check_bit("afull_o", exp_afull, afull);
      check_bit("aempty_o", exp_aempty, aempty);
      check_bit("wack_o", exp_wack, wack);
      check_bit("dvld_o", exp_dvld, dvld);
      check_bit("overflow_o", exp_ovf, ovf);
      check_bit("underflow_o", exp_unf, unf);
      if (rd_seen) begin
         check_data("rdata_o", exp_rdata, rdata);   // oldest word out or held
      end
   endtask

   // --------------------------------------------------
   // reference model
   // --------------------------------------------------

   // accept rules use the flags as they were before this edge
   task automatic model_step(input logic w, input logic r, input fifo_cfg_pkg::data_t d);
      logic        wr_acc;
      logic        rd_acc;
      int unsigned n;
      wr_acc     = w & ~exp_full;
      rd_acc     = r & ~exp_empty;
      exp_wack   = wr_acc;
      exp_dvld   = rd_acc;
      exp_ovf    = w & exp_full;
      exp_unf    = r & exp_empty;
      if (rd_acc) begin
         exp_rdata = model_q.pop_front();
      end
      if (wr_acc) begin
         model_q.push_back(d);
      end
      n          = model_q.size();
      exp_level  = fifo_cfg_pkg::level_t'(n);
      exp_full   = (n == fifo_cfg_pkg::DEPTH);
      exp_empty  = (n == 0);
      exp_afull  = (n >= AFULL_VAL);
      exp_aempty = (n <= AEMPTY_VAL);
      rd_seen    = rd_seen | rd_acc;
      seen_full  = seen_full | exp_full;
      seen_ovf   = seen_ovf | exp_ovf;
      seen_unf   = seen_unf | exp_unf;
      seen_both  = seen_both | (wr_acc & rd_acc);
   endtask

   // phase 0 leans to writes, phase 1 to reads, phase 2 is balanced
   task automatic drive_request(input int phase);
      logic b0;
      logic b1;
      logic b2;
      logic b3;
      b0 = take_bit();
      b1 = take_bit();
      if (phase == 2) begin
         we = b0;
         re = b1;
      end else begin
         b2 = take_bit();
         b3 = take_bit();
         we = (phase == 0) ? (b0 | b1) : (b0 & b1);
         re = (phase == 0) ? (b2 & b3) : (b2 | b3);
      end
      for (int i = 0; i < fifo_cfg_pkg::DATA_W; i++) begin
         wdata[i] = take_bit();
      end
      model_step(we, re, wdata);
   endtask

   // --------------------------------------------------
   // cycle limit
   // --------------------------------------------------
   initial begin
      cycle_cnt = 0;
      forever begin
         @(posedge pos_clk);
         cycle_cnt++;
         if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Simulation finished: FAIL");
            $fatal(1, "cycle limit reached");
         end
      end
   end

   // --------------------------------------------------
   // main sequence
   // --------------------------------------------------
   initial begin
      aresetn    = 1'b0;
      we         = 1'b0;
      re         = 1'b0;
      wdata      = '0;
      lfsr_state = SEED;
      exp_rdata  = '0;
      exp_level  = '0;
      exp_full   = 1'b0;
      exp_empty  = 1'b1;
      exp_afull  = 1'b0;
      exp_aempty = 1'b1;
      exp_wack   = 1'b0;
      exp_dvld   = 1'b0;
      exp_ovf    = 1'b0;
      exp_unf    = 1'b0;
      rd_seen    = 1'b0;
      seen_full  = 1'b0;
      seen_ovf   = 1'b0;
      seen_unf   = 1'b0;
      seen_both  = 1'b0;

      repeat (2) @(posedge pos_clk);
      #(DRIVE_SKEW);
      aresetn = 1'b1;
      check_reset_state();

      // each pass checks the previous request and then drives the next
      for (int k = 0; k < TEST_LEN; k++) begin
         @(posedge pos_clk);
         #(DRIVE_SKEW);
         check_outputs();
         drive_request(k / PHASE_LEN);
      end
      @(posedge pos_clk);
      #(DRIVE_SKEW);
      check_outputs();     // last request
      we = 1'b0;
      re = 1'b0;

      if (i_dut.i_assert.fail_cnt == 0 && seen_full && seen_ovf && seen_unf && seen_both) begin
         $display("Simulation finished: PASS");
         $finish;
      end else begin
         $display("run incomplete or assertion failed");
         $display("asserts %0d full %0b ovf %0b unf %0b both %0b",
                  i_dut.i_assert.fail_cnt, seen_full, seen_ovf, seen_unf, seen_both);
         $display("Simulation finished: FAIL");
         $fatal(1, "final check failed");
      end
   end

endmodule
